/* src/rvCorePkg.sv */
// shared widths, control enums and opcode encodings for the rv64i core and its testbench
package rvCorePkg;

  localparam int xlen = 64; // integer register and data width
  localparam int ilen = 32; // instruction width
  localparam int byteLanes = xlen / 8; // byte strobes per data word

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluCopyB // lui, operand b straight through
  } aluOpE;

  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ,
    immR // register ops, no immediate
  } extOpE;

  typedef enum logic [2:0] {
    brNone,
    brJal,
    brJalr,
    brEq,
    brNe,
    brLt, // signed or unsigned, set by alu op
    brGe
  } branchOpE;

  typedef enum logic [2:0] {
    memNone,
    memB,
    memH,
    memW,
    memD,
    memBu,
    memHu,
    memWu
  } memOpE;

  typedef enum logic {
    selPc,
    selRs1
  } srcASelE;

  typedef enum logic [1:0] {
    selRs2,
    selImm,
    selFour
  } srcBSelE;

  typedef enum logic [1:0] {
    trapNone,
    trapEbreak,
    trapIllegal
  } trapE;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeE;

endpackage

/* src/controlDecoder.sv */
// combinational rv64i decoder, turns one instruction word into datapath controls and a trap cause
`timescale 1ns/100ps

module controlDecoder (
  input  logic [rvCorePkg::ilen-1:0] instr,
  output rvCorePkg::aluOpE           aluOp,
  output rvCorePkg::extOpE           extOp,
  output rvCorePkg::branchOpE        branchOp,
  output rvCorePkg::memOpE           memOp,
  output rvCorePkg::srcASelE         srcASel,
  output rvCorePkg::srcBSelE         srcBSel,
  output rvCorePkg::trapE            trap,
  output logic                       regWen,
  output logic                       memToReg,
  output logic                       memWen
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic illegal;
  rvCorePkg::aluOpE aluFn; // shared op table for OP and OP-IMM

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    case (funct3)
      3'b000: aluFn = (opcode == rvCorePkg::opReg && instr[30]) ? rvCorePkg::aluSub
                                                               : rvCorePkg::aluAdd; // addi ignores bit 30
      3'b001: aluFn = rvCorePkg::aluSll;
      3'b010: aluFn = rvCorePkg::aluSlt;
      3'b011: aluFn = rvCorePkg::aluSltu;
      3'b100: aluFn = rvCorePkg::aluXor;
      3'b101: aluFn = instr[30] ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
      3'b110: aluFn = rvCorePkg::aluOr;
      default: aluFn = rvCorePkg::aluAnd;
    endcase
  end

  always_comb begin
    aluOp    = rvCorePkg::aluAdd;
    extOp    = rvCorePkg::immR;
    branchOp = rvCorePkg::brNone;
    memOp    = rvCorePkg::memNone;
    srcASel  = rvCorePkg::selRs1;
    srcBSel  = rvCorePkg::selRs2;
    trap     = rvCorePkg::trapNone;
    regWen   = 1'b0;
    memToReg = 1'b0;
    memWen   = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      rvCorePkg::opLui: begin
        srcBSel = rvCorePkg::selImm;
        aluOp   = rvCorePkg::aluCopyB; // rd = imm
        extOp   = rvCorePkg::immU;
        regWen  = 1'b1;
      end
      rvCorePkg::opAuipc: begin
        srcASel = rvCorePkg::selPc;
        srcBSel = rvCorePkg::selImm;
        extOp   = rvCorePkg::immU;
        regWen  = 1'b1;
      end
      rvCorePkg::opJal: begin
        srcASel  = rvCorePkg::selPc; // link value pc+4 out of the alu
        srcBSel  = rvCorePkg::selFour;
        extOp    = rvCorePkg::immJ;
        branchOp = rvCorePkg::brJal;
        regWen   = 1'b1;
      end
      rvCorePkg::opJalr: begin
        srcASel  = rvCorePkg::selPc;
        srcBSel  = rvCorePkg::selFour;
        extOp    = rvCorePkg::immI;
        branchOp = rvCorePkg::brJalr;
        regWen   = 1'b1;
        illegal  = (funct3 != 3'b000);
      end
      rvCorePkg::opBranch: begin
        extOp = rvCorePkg::immB; // compare rs1 against rs2
        case (funct3)
          3'b000: begin aluOp = rvCorePkg::aluSub;  branchOp = rvCorePkg::brEq; end
          3'b001: begin aluOp = rvCorePkg::aluSub;  branchOp = rvCorePkg::brNe; end
          3'b100: begin aluOp = rvCorePkg::aluSlt;  branchOp = rvCorePkg::brLt; end
          3'b101: begin aluOp = rvCorePkg::aluSlt;  branchOp = rvCorePkg::brGe; end
          3'b110: begin aluOp = rvCorePkg::aluSltu; branchOp = rvCorePkg::brLt; end
          3'b111: begin aluOp = rvCorePkg::aluSltu; branchOp = rvCorePkg::brGe; end
          default: illegal = 1'b1; // 010, 011
        endcase
      end
      rvCorePkg::opLoad: begin
        srcBSel  = rvCorePkg::selImm; // address = rs1 + imm
        extOp    = rvCorePkg::immI;
        memToReg = 1'b1;
        regWen   = 1'b1;
        case (funct3)
          3'b000: memOp = rvCorePkg::memB;
          3'b001: memOp = rvCorePkg::memH;
          3'b010: memOp = rvCorePkg::memW;
          3'b011: memOp = rvCorePkg::memD;
          3'b100: memOp = rvCorePkg::memBu;
          3'b101: memOp = rvCorePkg::memHu;
          3'b110: memOp = rvCorePkg::memWu;
          default: illegal = 1'b1;
        endcase
      end
      rvCorePkg::opStore: begin
        srcBSel = rvCorePkg::selImm;
        extOp   = rvCorePkg::immS;
        memWen  = 1'b1;
        case (funct3)
          3'b000: memOp = rvCorePkg::memB;
          3'b001: memOp = rvCorePkg::memH;
          3'b010: memOp = rvCorePkg::memW;
          3'b011: memOp = rvCorePkg::memD;
          default: illegal = 1'b1;
        endcase
      end
      rvCorePkg::opImm: begin
        srcBSel = rvCorePkg::selImm;
        extOp   = rvCorePkg::immI;
        aluOp   = aluFn;
        regWen  = 1'b1;
        if (funct3 == 3'b001) begin
          illegal = (instr[31:26] != 6'b000000); // slli, 6-bit shamt
        end else if (funct3 == 3'b101) begin
          illegal = (instr[31:26] != 6'b000000) && (instr[31:26] != 6'b010000);
        end
      end
      rvCorePkg::opReg: begin
        aluOp  = aluFn;
        regWen = 1'b1;
        if (funct7 == 7'b0100000) begin
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101); // only sub and sra
        end else begin
          illegal = (funct7 != 7'b0000000); // mul/div land here too
        end
      end
      rvCorePkg::opSystem: begin
        if (instr == 32'h0010_0073) begin
          trap = rvCorePkg::trapEbreak;
        end else begin
          illegal = 1'b1; // ecall, csr ops
        end
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      trap     = rvCorePkg::trapIllegal;
      regWen   = 1'b0;
      memWen   = 1'b0;
      memToReg = 1'b0;
    end
  end

endmodule

/* src/immGen.sv */
// immediate generator, sign extends the instruction's immediate field for the decoded format
`timescale 1ns/100ps

module immGen (
  input  logic [rvCorePkg::ilen-1:0] instr,
  input  rvCorePkg::extOpE           extOp,
  output logic [rvCorePkg::xlen-1:0] imm
);

  logic sign;

  assign sign = instr[31]; // every format keeps its sign in bit 31

  always_comb begin
    case (extOp)
      rvCorePkg::immI: imm = {{52{sign}}, instr[31:20]};
      rvCorePkg::immS: imm = {{52{sign}}, instr[31:25], instr[11:7]};
      rvCorePkg::immB: imm = {{51{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      rvCorePkg::immU: imm = {{32{sign}}, instr[31:12], 12'b0};
      rvCorePkg::immJ: imm = {{43{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:         imm = '0; // immR
    endcase
  end

endmodule

/* src/alu.sv */
// 64-bit alu for arithmetic, logic, shifts and compares, zero flag feeds beq/bne
`timescale 1ns/100ps

module alu (
  input  logic [rvCorePkg::xlen-1:0] opA,
  input  logic [rvCorePkg::xlen-1:0] opB,
  input  rvCorePkg::aluOpE           aluOp,
  output logic [rvCorePkg::xlen-1:0] aluResult,
  output logic                       zero
);

  logic [5:0] shamt;
  logic       lessSigned;
  logic       lessUnsigned;

  assign shamt        = opB[5:0]; // rv64 shift amount
  assign lessSigned   = $signed(opA) < $signed(opB);
  assign lessUnsigned = opA < opB;

  always_comb begin
    case (aluOp)
      rvCorePkg::aluAdd:   aluResult = opA + opB;
      rvCorePkg::aluSub:   aluResult = opA - opB;
      rvCorePkg::aluSll:   aluResult = opA << shamt;
      rvCorePkg::aluSlt:   aluResult = {{(rvCorePkg::xlen-1){1'b0}}, lessSigned};
      rvCorePkg::aluSltu:  aluResult = {{(rvCorePkg::xlen-1){1'b0}}, lessUnsigned};
      rvCorePkg::aluXor:   aluResult = opA ^ opB;
      rvCorePkg::aluSrl:   aluResult = opA >> shamt;
      rvCorePkg::aluSra:   aluResult = $unsigned($signed(opA) >>> shamt); // sign fill
      rvCorePkg::aluOr:    aluResult = opA | opB;
      rvCorePkg::aluAnd:   aluResult = opA & opB;
      rvCorePkg::aluCopyB: aluResult = opB;
      default:             aluResult = opA + opB;
    endcase
  end

  assign zero = (aluResult == '0); // equal when sub gives zero

endmodule

/* src/regFile.sv */
// integer register file, x0 reads zero, two async read ports and one clocked write port
`timescale 1ns/100ps

module regFile (
  input  logic                       clk,
  input  logic [4:0]                 rs1,
  input  logic [4:0]                 rs2,
  input  logic [4:0]                 rd,
  input  logic                       wen,
  input  logic [rvCorePkg::xlen-1:0] wdata,
  output logic [rvCorePkg::xlen-1:0] rs1Data,
  output logic [rvCorePkg::xlen-1:0] rs2Data
);

  logic [rvCorePkg::xlen-1:0] regs [1:31]; // no storage for x0

  always_ff @(posedge clk) begin
    if (wen && rd != 5'd0) begin // x0 writes dropped
      regs[rd] <= wdata;
    end
  end

  assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* src/pcUnit.sv */
// program counter with next-pc select for branches and jumps, plus the sticky halt and trap cause
`timescale 1ns/100ps

module pcUnit #(
  parameter logic [rvCorePkg::xlen-1:0] resetPc = 64'h0000_0000_8000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  input  rvCorePkg::branchOpE        branchOp,
  input  logic                       zero,
  input  logic                       lessBit, // slt/sltu result bit
  input  logic [rvCorePkg::xlen-1:0] imm,
  input  logic [rvCorePkg::xlen-1:0] rs1Data,
  input  rvCorePkg::trapE            trap,
  output logic [rvCorePkg::xlen-1:0] pc,
  output logic                       halted,
  output rvCorePkg::trapE            trapCause
);

  logic                       taken;
  logic [rvCorePkg::xlen-1:0] jalrTarget;
  logic [rvCorePkg::xlen-1:0] nextPc;

  always_comb begin
    case (branchOp)
      rvCorePkg::brJal: taken = 1'b1;
      rvCorePkg::brEq:  taken = zero;
      rvCorePkg::brNe:  taken = ~zero; // inverted compare
      rvCorePkg::brLt:  taken = lessBit;
      rvCorePkg::brGe:  taken = ~lessBit;
      default:          taken = 1'b0; // brNone, jalr handled apart
    endcase
  end

  assign jalrTarget = (rs1Data + imm) & ~64'd1; // bit 0 cleared
  assign nextPc = (branchOp == rvCorePkg::brJalr) ? jalrTarget
                : taken                           ? pc + imm
                                                  : pc + 64'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= resetPc;
      halted    <= 1'b0;
      trapCause <= rvCorePkg::trapNone;
    end else if (!halted) begin
      if (trap != rvCorePkg::trapNone) begin
        halted    <= 1'b1; // pc stays on the trapping instruction
        trapCause <= trap;
      end else begin
        pc <= nextPc;
      end
    end
  end

endmodule

/* src/loadStoreUnit.sv */
// byte lane steering for the data port, store mask and data shift plus load extract and extend
`timescale 1ns/100ps

module loadStoreUnit (
  input  logic [2:0]                      addr, // byte offset in the doubleword
  input  rvCorePkg::memOpE                memOp,
  input  logic [rvCorePkg::xlen-1:0]      storeData,
  input  logic [rvCorePkg::xlen-1:0]      rdata,
  output logic [rvCorePkg::byteLanes-1:0] wmask,
  output logic [rvCorePkg::xlen-1:0]      wdata,
  output logic [rvCorePkg::xlen-1:0]      loadData
);

  logic [5:0]                      bitShift;
  logic [rvCorePkg::byteLanes-1:0] baseMask;
  logic [rvCorePkg::xlen-1:0]      lane;

  assign bitShift = {addr, 3'b000};

  always_comb begin
    case (memOp)
      rvCorePkg::memB, rvCorePkg::memBu: baseMask = 8'h01;
      rvCorePkg::memH, rvCorePkg::memHu: baseMask = 8'h03;
      rvCorePkg::memW, rvCorePkg::memWu: baseMask = 8'h0f;
      rvCorePkg::memD:                   baseMask = 8'hff;
      default:                           baseMask = 8'h00;
    endcase
  end

  assign wmask = baseMask << addr; // aligned, never spills past lane 7
  assign wdata = storeData << bitShift;

  assign lane = rdata >> bitShift; // selected bytes down to bit 0

  always_comb begin
    case (memOp)
      rvCorePkg::memB:  loadData = {{56{lane[7]}}, lane[7:0]};
      rvCorePkg::memH:  loadData = {{48{lane[15]}}, lane[15:0]};
      rvCorePkg::memW:  loadData = {{32{lane[31]}}, lane[31:0]};
      rvCorePkg::memD:  loadData = lane;
      rvCorePkg::memBu: loadData = {56'b0, lane[7:0]};
      rvCorePkg::memHu: loadData = {48'b0, lane[15:0]};
      rvCorePkg::memWu: loadData = {32'b0, lane[31:0]};
      default:          loadData = '0;
    endcase
  end

endmodule

/* src/rvCore.sv */
// single-cycle rv64i core top, decoder plus datapath with external instruction and data ports
`timescale 1ns/100ps

module rvCore #(
  parameter logic [rvCorePkg::xlen-1:0] resetPc = 64'h0000_0000_8000_0000
) (
  input  logic                            clk,
  input  logic                            rst,
  output logic [rvCorePkg::xlen-1:0]      instrAddr,
  input  logic [rvCorePkg::ilen-1:0]      instr,
  output logic [rvCorePkg::xlen-1:0]      dataAddr,
  output logic [rvCorePkg::xlen-1:0]      dataWdata,
  output logic [rvCorePkg::byteLanes-1:0] dataWmask,
  output logic                            dataWen,
  input  logic [rvCorePkg::xlen-1:0]      dataRdata, // aligned doubleword at dataAddr
  output logic                            halted,
  output rvCorePkg::trapE                 trapCause
);

  rvCorePkg::aluOpE    aluOp;
  rvCorePkg::extOpE    extOp;
  rvCorePkg::branchOpE branchOp;
  rvCorePkg::memOpE    memOp;
  rvCorePkg::srcASelE  srcASel;
  rvCorePkg::srcBSelE  srcBSel;
  rvCorePkg::trapE     trap;
  logic regWen;
  logic memToReg;
  logic memWen;
  logic commitOk;
  logic zero;
  logic [rvCorePkg::xlen-1:0] pc;
  logic [rvCorePkg::xlen-1:0] imm;
  logic [rvCorePkg::xlen-1:0] rs1Data;
  logic [rvCorePkg::xlen-1:0] rs2Data;
  logic [rvCorePkg::xlen-1:0] opA;
  logic [rvCorePkg::xlen-1:0] opB;
  logic [rvCorePkg::xlen-1:0] aluResult;
  logic [rvCorePkg::xlen-1:0] loadData;
  logic [rvCorePkg::xlen-1:0] wbData;

  controlDecoder decoder (
    .instr(instr), .aluOp(aluOp), .extOp(extOp), .branchOp(branchOp), .memOp(memOp),
    .srcASel(srcASel), .srcBSel(srcBSel), .trap(trap),
    .regWen(regWen), .memToReg(memToReg), .memWen(memWen)
  );

  immGen immUnit (.instr(instr), .extOp(extOp), .imm(imm));

  // writes only retire from a live, non-trapping instruction
  assign commitOk = !rst && !halted && (trap == rvCorePkg::trapNone);

  regFile regs (
    .clk(clk), .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
    .wen(regWen && commitOk), .wdata(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  assign opA = (srcASel == rvCorePkg::selPc) ? pc : rs1Data;

  always_comb begin
    case (srcBSel)
      rvCorePkg::selImm:  opB = imm;
      rvCorePkg::selFour: opB = 64'd4; // link address for jal/jalr
      default:            opB = rs2Data;
    endcase
  end

  alu aluUnit (.opA(opA), .opB(opB), .aluOp(aluOp), .aluResult(aluResult), .zero(zero));

  loadStoreUnit lsu (
    .addr(aluResult[2:0]), .memOp(memOp), .storeData(rs2Data), .rdata(dataRdata),
    .wmask(dataWmask), .wdata(dataWdata), .loadData(loadData)
  );

  assign wbData = memToReg ? loadData : aluResult;

  pcUnit #(.resetPc(resetPc)) pcGen (
    .clk(clk), .rst(rst), .branchOp(branchOp), .zero(zero), .lessBit(aluResult[0]),
    .imm(imm), .rs1Data(rs1Data), .trap(trap),
    .pc(pc), .halted(halted), .trapCause(trapCause)
  );

  assign instrAddr = pc;
  assign dataAddr  = aluResult; // effective address
  assign dataWen   = memWen && commitOk;

endmodule

/* dv/rvCoreTb.sv */
// testbench for the rv64i core that checks random programs cycle by cycle against an ISA model
`timescale 1ns/100ps

module rvCoreTb;

  localparam logic [63:0] resetPc = 64'h0000_0000_0000_0100; // low so jalr can use x0 base
  localparam logic [63:0] dataBase = 64'h0000_0000_0000_2000; // lui x20, 2
  localparam int clkPeriod = 4;
  localparam int progLen = 300;
  localparam int runs = 4;
  localparam int tailStart = progLen - 16; // 15 dump stores and the final trap

  logic clk;
  logic rst = 1'b0;
  logic [63:0] instrAddr;
  logic [31:0] instr;
  logic [63:0] dataAddr;
  logic [63:0] dataWdata;
  logic [7:0] dataWmask;
  logic dataWen;
  logic [63:0] dataRdata;
  logic halted;
  rvCorePkg::trapE trapCause;

  logic [31:0] imem [0:progLen-1];
  logic [63:0] dmem [0:31]; // 256-byte window seen by the DUT
  logic [63:0] refMem [0:31]; // model copy of the same window
  logic [63:0] mRegs [0:31];
  logic [63:0] mPc;
  logic mHalted;
  rvCorePkg::trapE mTrap;
  logic expWen;
  logic [63:0] expAddr;
  logic [7:0] expMask;
  logic [63:0] expData;
  logic [63:0] rngState = 64'd91939;
  logic [63:0] iOff;
  logic [63:0] dOff;
  int runIdx = 0;

  rvCore #(.resetPc(resetPc)) UUT (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWmask(dataWmask), .dataWen(dataWen),
    .dataRdata(dataRdata), .halted(halted), .trapCause(trapCause)
  );

  // combinational memory reads
  assign iOff = instrAddr - resetPc;
  assign instr = (iOff < 64'(4 * progLen)) ? imem[iOff[10:2]] : 32'h0; // outside program traps
  assign dOff = dataAddr - dataBase;
  assign dataRdata = (dOff < 64'd256) ? dmem[dOff[7:3]] : 64'h0;

  function automatic logic [63:0] fillWord(input logic [63:0] addr, input int run);
    return (addr * 64'h9E37_79B9_7F4A_7C15) ^ {32'(run), addr[31:0]};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        dmem[i] <= fillWord(dataBase + 64'(8 * i), runIdx); // refilled on every reset
      end
    end else if (dataWen && dOff < 64'd256) begin
      for (int b = 0; b < 8; b++) begin
        if (dataWmask[b]) dmem[dOff[7:3]][8*b +: 8] <= dataWdata[8*b +: 8];
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(runs * (progLen + 50) * clkPeriod);
    failRun("watchdog expired, the core never finished its programs");
  end

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic int unsigned rnd();
    rngState = xorshift(rngState);
    return rngState[31:0];
  endfunction

  function automatic logic [4:0] pickReg(); // x1..x15
    return 5'(1 + rnd() % 15);
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) failRun($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkMask(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) failRun($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) failRun($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic checkTrap(input string name, input rvCorePkg::trapE exp,
                           input rvCorePkg::trapE act);
    if (act !== exp) begin
      failRun($sformatf("ERROR %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
  endtask

  // instruction encoders
  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic isKnownOp(input logic [6:0] op);
    return op inside {7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                      7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b1110011};
  endfunction

  task automatic genProgram(input logic endIllegal);
    int s;
    int k;
    int w;
    logic [2:0] f3;
    logic [4:0] r1;
    logic [6:0] op;
    logic [63:0] target;
    imem[0] = encS(12'h000, 5'd0, 5'd0, 3'b011); // store to address 0 fetched throughout reset
    for (int i = 1; i < 16; i++) imem[i] = encI(12'(rnd()), 5'd0, 3'b000, 5'(i), 7'b0010011);
    imem[16] = {20'h00002, 5'd20, 7'b0110111}; // lui x20, data base
    s = 17;
    while (s < tailStart) begin
      k = 1 + rnd() % ((tailStart - s) < 8 ? (tailStart - s) : 8); // forward hop
      f3 = 3'(rnd());
      case (rnd() % 16)
        0, 1, 2, 3, 4: begin
          imem[s] = {(f3 == 3'b000 || f3 == 3'b101) && rnd() % 2 == 1 ? 7'h20 : 7'h00,
                     pickReg(), pickReg(), f3, pickReg(), 7'b0110011};
        end
        5, 6, 7, 8: begin
          if (f3 == 3'b001) imem[s] = encI({6'b0, 6'(rnd())}, pickReg(), f3, pickReg(),
                                           7'b0010011);
          else if (f3 == 3'b101) imem[s] = encI({1'b0, 1'(rnd()), 4'b0, 6'(rnd())}, pickReg(),
                                                f3, pickReg(), 7'b0010011);
          else imem[s] = encI(12'(rnd()), pickReg(), f3, pickReg(), 7'b0010011);
        end
        9: imem[s] = {20'(rnd()), pickReg(), rnd() % 2 == 1 ? 7'b0110111 : 7'b0010111};
        10, 11: begin
          f3 = 3'(rnd() % 7); // any load width and sign
          w = 1 << f3[1:0];
          imem[s] = encI(12'((rnd() % (128 / w)) * w), 5'd20, f3, pickReg(), 7'b0000011);
        end
        12: begin
          f3 = 3'(rnd() % 4);
          w = 1 << f3[1:0];
          imem[s] = encS(12'((rnd() % (128 / w)) * w), pickReg(), 5'd20, f3);
        end
        13, 14: begin
          r1 = pickReg();
          f3 = (f3 == 3'b010 || f3 == 3'b011) ? 3'b000 : f3;
          imem[s] = encB(13'(4 * k), rnd() % 4 == 0 ? r1 : pickReg(), r1, f3);
        end
        default: begin
          if (rnd() % 2 == 1) begin
            imem[s] = encJ(21'(4 * k), pickReg());
          end else begin
            target = resetPc + 64'(4 * (s + k)) + 64'(rnd() % 2); // odd target tests bit 0
            imem[s] = encI(target[11:0], 5'd0, 3'b000, pickReg(), 7'b1100111);
          end
        end
      endcase
      s++;
    end
    for (int i = 1; i < 16; i++) begin
      imem[tailStart + i - 1] = encS(12'(128 + 8 * (i - 1)), 5'(i), 5'd20, 3'b011);
    end
    if (endIllegal) begin
      op = 7'(rnd());
      while (isKnownOp(op)) op = 7'(rnd());
      imem[progLen - 1] = {25'(rnd()), op};
    end else begin
      imem[progLen - 1] = 32'h0010_0073; // ebreak
    end
  endtask

  // ISA-level reference model stepping one instruction per call
  task automatic modelStep();
    logic [31:0] ins;
    logic [6:0] op;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] iImm;
    logic [63:0] sImm;
    logic [63:0] bImm;
    logic [63:0] jImm;
    logic [63:0] res;
    logic [63:0] nextPc;
    logic [63:0] off;
    logic [63:0] word;
    logic wr;
    logic take;
    logic [5:0] sh;
    ins = ((mPc - resetPc) < 64'(4 * progLen)) ? imem[(mPc - resetPc) >> 2] : 32'h0;
    op = ins[6:0];
    f3 = ins[14:12];
    rd = ins[11:7];
    a = mRegs[ins[19:15]];
    b = mRegs[ins[24:20]];
    iImm = {{52{ins[31]}}, ins[31:20]};
    sImm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    bImm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    jImm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    expWen = 1'b0;
    expMask = 8'h00;
    expAddr = 64'h0;
    expData = 64'h0;
    res = 64'h0;
    wr = 1'b0;
    nextPc = mPc + 64'd4;
    case (op)
      7'b0110111: begin
        res = {{32{ins[31]}}, ins[31:12], 12'b0};
        wr = 1'b1;
      end
      7'b0010111: begin
        res = mPc + {{32{ins[31]}}, ins[31:12], 12'b0};
        wr = 1'b1;
      end
      7'b1101111: begin
        res = mPc + 64'd4;
        wr = 1'b1;
        nextPc = mPc + jImm;
      end
      7'b1100111: begin
        res = mPc + 64'd4;
        wr = 1'b1;
        nextPc = (a + iImm) & ~64'd1;
      end
      7'b1100011: begin
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          3'b110: take = (a < b);
          default: take = (a >= b);
        endcase
        if (take) nextPc = mPc + bImm;
      end
      7'b0000011: begin
        off = a + iImm - dataBase;
        word = refMem[off[7:3]] >> (8 * off[2:0]);
        case (f3)
          3'b000: res = {{56{word[7]}}, word[7:0]};
          3'b001: res = {{48{word[15]}}, word[15:0]};
          3'b010: res = {{32{word[31]}}, word[31:0]};
          3'b100: res = {56'b0, word[7:0]};
          3'b101: res = {48'b0, word[15:0]};
          3'b110: res = {32'b0, word[31:0]};
          default: res = word;
        endcase
        wr = 1'b1;
      end
      7'b0100011: begin
        expWen = 1'b1;
        expAddr = a + sImm;
        expMask = 8'(((1 << (1 << f3[1:0])) - 1) << expAddr[2:0]);
        expData = b << (8 * expAddr[2:0]);
        for (int i = 0; i < 8; i++) if (!expMask[i]) expData[8*i +: 8] = 8'h00;
      end
      7'b0010011, 7'b0110011: begin
        if (op == 7'b0010011) b = iImm;
        sh = b[5:0];
        case (f3)
          3'b000: res = (op == 7'b0110011 && ins[30]) ? a - b : a + b;
          3'b001: res = a << sh;
          3'b010: res = {63'b0, $signed(a) < $signed(b)};
          3'b011: res = {63'b0, a < b};
          3'b100: res = a ^ b;
          3'b101: res = ins[30] ? 64'($signed(a) >>> sh) : a >> sh;
          3'b110: res = a | b;
          default: res = a & b;
        endcase
        wr = 1'b1;
      end
      7'b1110011: mTrap = (ins == 32'h0010_0073) ? rvCorePkg::trapEbreak
                                                 : rvCorePkg::trapIllegal;
      default: mTrap = rvCorePkg::trapIllegal;
    endcase
    if (mTrap != rvCorePkg::trapNone) begin
      expWen = 1'b0; // trapping instruction commits nothing
      mHalted = 1'b1;
    end else begin
      if (wr && rd != 5'd0) mRegs[rd] = res;
      if (expWen) begin
        off = expAddr - dataBase;
        if (off < 64'd256) begin // stores outside the window are dropped
          for (int i = 0; i < 8; i++) begin
            if (expMask[i]) refMem[off[7:3]][8*i +: 8] = expData[8*i +: 8];
          end
        end
      end
      mPc = nextPc;
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      checkFlag("dataWen during reset", 1'b0, dataWen);
    end
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic runProgram();
    int cyc;
    int haltCycles;
    cyc = 0;
    haltCycles = 0;
    while (haltCycles < 3 && cyc < progLen + 20) begin
      @(negedge clk);
      if (cyc == 0) begin
        checkWord("pc after reset", resetPc, instrAddr);
        checkTrap("trap cause after reset", rvCorePkg::trapNone, trapCause);
      end
      if (!mHalted) begin
        checkFlag("halted while running", 1'b0, halted);
        checkWord("pc", mPc, instrAddr);
        modelStep();
        checkFlag("store strobe", expWen, dataWen);
        if (expWen) begin
          checkWord("store address", expAddr, dataAddr);
          checkMask("store mask", expMask, dataWmask);
          checkWord("store data", expData, dataWdata & {
                    {8{dataWmask[7]}}, {8{dataWmask[6]}}, {8{dataWmask[5]}}, {8{dataWmask[4]}},
                    {8{dataWmask[3]}}, {8{dataWmask[2]}}, {8{dataWmask[1]}}, {8{dataWmask[0]}}});
        end
      end else begin
        haltCycles++;
        checkFlag("halted after trap", 1'b1, halted);
        checkTrap("trap cause", mTrap, trapCause);
        checkWord("pc held in halt", mPc, instrAddr);
        checkFlag("store strobe in halt", 1'b0, dataWen);
      end
      cyc++;
    end
    if (haltCycles < 3) failRun("core did not halt at the end of the program");
  endtask

  initial begin
    for (int r = 0; r < runs; r++) begin
      runIdx = r;
      genProgram(r == runs - 1); // last run ends on an illegal opcode
      for (int i = 0; i < 32; i++) begin
        mRegs[i] = 64'h0;
        refMem[i] = fillWord(dataBase + 64'(8 * i), r);
      end
      mPc = resetPc;
      mHalted = 1'b0;
      mTrap = rvCorePkg::trapNone;
      applyReset();
      runProgram();
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* sim.f */
src/rvCorePkg.sv
src/controlDecoder.sv
src/immGen.sv
src/alu.sv
src/regFile.sv
src/pcUnit.sv
src/loadStoreUnit.sv
src/rvCore.sv
dv/rvCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the rv64i core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module rvCoreTb -f sim.f -Mdir obj_dir -o rvCoreSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/rvCoreSim | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
